// File: run_sim.sh
#!/bin/sh
# Build and run the rv_mini_core testbench with Verilator.
# Exit status is nonzero when the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f rv_mini_core.f \
    --top-module rv_mini_core_tb \
    --Mdir obj_dir \
    -o rv_mini_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/rv_mini_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: rv_mini_core.f
+incdir+verif
verilog/rv_core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_issue.sv
verilog/register_file.sv
verilog/alu_unit.sv
verilog/branch_unit.sv
verilog/load_store_unit.sv
verilog/rv_mini_core.sv
verif/rv_mini_core_asserts.sv
verif/rv_mini_core_tb.sv

// File: verif/rv_mini_core_asserts.sv
/* Memory port protocol checks, bound into the core top.
   Checks start one cycle into reset, once the sequencer has settled. */

`timescale 1ns/1ps

module rv_mini_core_asserts (
    input logic clk,
    input logic reset,
    input logic imem_req,
    input logic dmem_req
);

    // Both strobes quiet while reset holds
    assert property (@(posedge clk) (reset && $past(reset)) |-> (!imem_req && !dmem_req))
        else $error("memory strobe high during reset");

    // Instruction strobe is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset) imem_req |=> !imem_req)
        else $error("imem_req high on two consecutive cycles");

    // Only one instruction in flight
    assert property (@(posedge clk) disable iff (reset) !(imem_req && dmem_req))
        else $error("dmem_req coincides with imem_req");

endmodule

bind rv_mini_core rv_mini_core_asserts asserts_i (
    .clk (clk),
    .reset (reset),
    .imem_req (imem_req),
    .dmem_req (dmem_req)
);

// File: verif/rv_mini_core_tests.svh
/* Directed tests, included in the testbench top. Each test builds a program,
   runs it from reset and compares the stores it makes, in order. */

`ifndef RV_MINI_CORE_TESTS_SVH
`define RV_MINI_CORE_TESTS_SVH

////////////////////////////////////////////////////
// Instruction encoding
function automatic instr_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
endfunction

function automatic instr_t enc_i(int imm, int rs1, int f3, int rd, opcode_t opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic instr_t enc_s(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic instr_t enc_b(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic instr_t enc_j(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
endfunction

function automatic word_t bool_word(input logic c);
    return {31'b0, c};
endfunction

// Branch outcome per the RV32I condition codes
function automatic logic taken_for(int f3, word_t a, word_t b);
    case (f3)
        0: return a == b;
        1: return a != b;
        4: return $signed(a) < $signed(b);
        5: return $signed(a) >= $signed(b);
        6: return a < b;
        default: return a >= b;
    endcase
endfunction

////////////////////////////////////////////////////
// Program building
task automatic begin_test();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    st_ptr = 0;
endtask

function automatic addr_t pc_now();
    return addr_t'(prog.size() * 4);
endfunction

// LUI plus ADDI with the upper part rounded for the signed low half
task automatic load_imm(int rd, word_t v);
    word_t hi;
    hi = (v + 32'h800) >> 12;
    prog.push_back({hi[19:0], rd[4:0], OPC_LUI});
    prog.push_back(enc_i(v, rd, 0, rd, OPC_OP_IMM));
endtask

task automatic sw_expect(int rs2, word_t expv);
    addr_t a;
    a = STORE_BASE + addr_t'(st_ptr * 4);
    prog.push_back(enc_s(a, rs2, 0));
    exp_addr.push_back(a);
    exp_data.push_back(expv);
    st_ptr++;
endtask

task automatic op_rr(int f3, int f7, int rs1, int rs2, word_t expv);
    prog.push_back(enc_r(f7, rs2, rs1, f3, 5));
    sw_expect(5, expv);
endtask

task automatic op_ri(int f3, int imm, int rs1, word_t expv);
    prog.push_back(enc_i(imm, rs1, f3, 5, OPC_OP_IMM));
    sw_expect(5, expv);
endtask

task automatic run_program(input string name);
    int i;
    int limit;
    addr_t park;
    for (i = 0; i < 256; i++) begin
        imem_mem[i] = 32'h00000013;
    end
    for (i = 0; i < prog.size(); i++) begin
        imem_mem[i] = prog[i];
    end
    // Park on a jump to itself
    park = pc_now();
    imem_mem[prog.size()] = enc_j(0, 0);
    limit = 4 * (prog.size() + 1) + 100;
    cycle_limit += limit + 12;
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (10) @(posedge clk);
    #2 reset = 1'b0;
    // Program has ended once the parking jump is fetched
    do begin
        @(negedge clk);
    end while (!(imem_req && imem.addr == park));
    if (st_addr_q.size() != exp_addr.size()) begin
        $display("%s: %0d stores were seen where %0d were expected",
                 name, st_addr_q.size(), exp_addr.size());
        stop_on_error();
    end
    for (i = 0; i < exp_addr.size(); i++) begin
        check_addr("dmem.addr", st_addr_q[i], exp_addr[i]);
        check_word("dmem.wdata", st_data_q[i], exp_data[i]);
    end
endtask

////////////////////////////////////////////////////
// Tests
task automatic alu_test();
    word_t a;
    word_t b;
    a = -20;
    b = 3;
    begin_test();
    load_imm(1, a);
    load_imm(2, b);
    op_rr(0, 0, 1, 2, a + b);
    op_rr(0, 32, 1, 2, a - b);
    op_rr(7, 0, 1, 2, a & b);
    op_rr(6, 0, 1, 2, a | b);
    op_rr(4, 0, 1, 2, a ^ b);
    op_rr(2, 0, 1, 2, bool_word($signed(a) < $signed(b)));
    op_rr(3, 0, 1, 2, bool_word(a < b));
    op_rr(1, 0, 1, 2, a << 3);
    op_rr(5, 0, 1, 2, a >> 3);
    op_rr(5, 32, 1, 2, word_t'($signed(a) >>> 3));
    // SLTIU compares against a sign-extended immediate
    op_ri(0, 100, 1, a + 100);
    op_ri(7, 12'h0f0, 1, a & 32'h0f0);
    op_ri(6, 12'h0f0, 1, a | 32'h0f0);
    op_ri(4, -1, 1, ~a);
    op_ri(2, -5, 1, bool_word($signed(a) < -5));
    op_ri(3, -5, 1, bool_word(a < 32'hfffffffb));
    op_ri(1, 4, 1, a << 4);
    op_ri(5, 4, 1, a >> 4);
    op_ri(5, 12'h404, 1, word_t'($signed(a) >>> 4));
    load_imm(3, 32'h7ffff001);
    prog.push_back(enc_i(0, 3, 0, 5, OPC_OP_IMM));
    sw_expect(5, 32'h7ffff001);
    run_program("alu_test");
endtask

task automatic branch_case(int f3, int rs1, int rs2, word_t a, word_t b, int marker);
    word_t m;
    m = taken_for(f3, a, b) ? marker + 1 : marker;
    prog.push_back(enc_b(12, rs2, rs1, f3));
    prog.push_back(enc_i(marker, 0, 0, 6, OPC_OP_IMM));
    prog.push_back(enc_j(8, 0));
    prog.push_back(enc_i(marker + 1, 0, 0, 6, OPC_OP_IMM));
    sw_expect(6, m);
endtask

task automatic branch_test();
    int k;
    int conds [6];
    word_t v [4];
    conds = '{0, 1, 4, 5, 6, 7};
    v = '{0, 5, 5, -2};
    begin_test();
    load_imm(1, v[1]);
    load_imm(2, v[2]);
    load_imm(3, v[3]);
    for (k = 0; k < 6; k++) begin
        branch_case(conds[k], 1, 2, v[1], v[2], 16 * k + 2);
        branch_case(conds[k], 1, 3, v[1], v[3], 16 * k + 6);
        branch_case(conds[k], 3, 1, v[3], v[1], 16 * k + 10);
    end
    run_program("branch_test");
endtask

task automatic jal_test();
    addr_t p;
    begin_test();
    prog.push_back(enc_i(1, 0, 0, 8, OPC_OP_IMM));
    p = pc_now();
    prog.push_back(enc_j(8, 7));
    prog.push_back(enc_i(99, 0, 0, 8, OPC_OP_IMM));
    sw_expect(7, p + 4);
    sw_expect(8, 1);
    run_program("jal_test");
endtask

task automatic load_store_test();
    word_t a;
    word_t b;
    a = fill_word(8'h10);
    b = fill_word(8'h11);
    begin_test();
    prog.push_back(enc_i(12'h040, 0, 2, 1, OPC_LOAD));
    prog.push_back(enc_i(12'h044, 0, 2, 2, OPC_LOAD));
    op_rr(0, 0, 1, 2, a + b);
    load_imm(4, 32'h300);
    prog.push_back(enc_i(12'h048, 0, 2, 9, OPC_LOAD));
    prog.push_back(enc_s(8, 9, 4));
    exp_addr.push_back(32'h308);
    exp_data.push_back(fill_word(8'h12));
    // Reload what was just stored
    prog.push_back(enc_i(8, 4, 2, 10, OPC_LOAD));
    prog.push_back(enc_r(0, 1, 10, 0, 11));
    sw_expect(11, fill_word(8'h12) + a);
    run_program("load_store_test");
endtask

task automatic zero_reg_test();
    begin_test();
    load_imm(1, 32'h12345678);
    prog.push_back(enc_i(123, 0, 0, 0, OPC_OP_IMM));
    sw_expect(0, 0);
    prog.push_back(enc_r(0, 1, 1, 0, 0));
    sw_expect(0, 0);
    op_rr(0, 0, 0, 1, 32'h12345678);
    run_program("zero_reg_test");
endtask

task automatic random_test();
    int k;
    word_t a;
    word_t b;
    begin_test();
    for (k = 0; k < 6; k++) begin
        a = $random(seed);
        b = $random(seed);
        load_imm(1, a);
        load_imm(2, b);
        op_rr(0, 0, 1, 2, a + b);
        op_rr(0, 32, 1, 2, a - b);
        op_rr(4, 0, 1, 2, a ^ b);
        op_rr(3, 0, 1, 2, bool_word(a < b));
    end
    run_program("random_test");
endtask

`endif

// File: verif/rv_mini_core_tb.sv
/* Testbench for the multi-cycle core. Memories are 256 words each and
   word addressed; data memory is refilled with a fixed pattern during reset. */

`timescale 1ns/1ps

module rv_mini_core_tb
    import rv_core_pkg::*;
    ();

    localparam addr_t STORE_BASE = 32'h200;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic imem_req;
    mem_req_t imem;
    instr_t instr_rdata = '0;
    logic dmem_req;
    mem_req_t dmem;
    word_t dmem_rdata = '0;

    instr_t imem_mem [256];
    word_t dmem_mem [256];

    // Stores seen on the data port, in order
    addr_t st_addr_q [$];
    word_t st_data_q [$];

    // Program under construction and its expected stores
    instr_t prog [$];
    addr_t exp_addr [$];
    word_t exp_data [$];
    int st_ptr;

    int cycles = 0;
    int cycle_limit = 20;
    int seed = 32'h9ae91f6b;

    logic imem_pend;
    addr_t imem_addr_l;
    logic dmem_rd_pend;
    addr_t dmem_rd_addr;

    rv_mini_core #(.RESET_VECTOR(32'h0)) rv_mini_core_i (
        .clk (clk),
        .reset (reset),
        .imem_req (imem_req),
        .imem (imem),
        .instr_rdata (instr_rdata),
        .dmem_req (dmem_req),
        .dmem (dmem),
        .dmem_rdata (dmem_rdata)
    );

    always #20 clk = ~clk;

    function automatic word_t fill_word(input logic [7:0] w);
        return {w, ~w, w ^ 8'h3c, 8'ha5};
    endfunction

    ////////////////////////////////////////////////////
    // Memory models
    always @(negedge clk) begin : mem_sample
        int i;
        imem_pend = imem_req;
        imem_addr_l = imem.addr;
        dmem_rd_pend = dmem_req && !dmem.we;
        dmem_rd_addr = dmem.addr;
        if (reset) begin
            for (i = 0; i < 256; i++) begin
                dmem_mem[i] = fill_word(i[7:0]);
            end
            st_addr_q.delete();
            st_data_q.delete();
        end else if (dmem_req && dmem.we) begin
            dmem_mem[dmem.addr[9:2]] = dmem.wdata;
            st_addr_q.push_back(dmem.addr);
            st_data_q.push_back(dmem.wdata);
        end
    end

    // Read data on the cycle after the strobe
    always @(posedge clk) begin
        #2;
        if (imem_pend) begin
            instr_rdata = imem_mem[imem_addr_l[9:2]];
        end
        if (dmem_rd_pend) begin
            dmem_rdata = dmem_mem[dmem_rd_addr[9:2]];
        end
    end

    ////////////////////////////////////////////////////
    // Failure handling and checks
    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t expv);
        if (got !== expv) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expv);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expv);
        if (got !== expv) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expv);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run took more than %0d cycles", cycle_limit);
            stop_on_error();
        end
    end

    `include "rv_mini_core_tests.svh"

    initial begin
        alu_test();
        branch_test();
        jal_test();
        load_store_test();
        zero_reg_test();
        random_test();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verilog/alu_unit.sv
/* Single-cycle integer ALU. Result is written back on the issue cycle. */

`timescale 1ns/1ps

module alu_unit
    import rv_core_pkg::*;
    (
        input logic issue,
        input issue_packet_t issue_pkt,

        output wb_packet_t wb
    );

    word_t a;
    word_t b;
    word_t result;
    logic [4:0] shamt;

    assign a = issue_pkt.rs1;
    assign b = issue_pkt.use_imm ? issue_pkt.imm : issue_pkt.rs2;
    assign shamt = b[4:0];

    ////////////////////////////////////////////////////
    // Operations
    always_comb begin
        case (issue_pkt.alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            // LUI carries its value in the immediate
            ALU_PASS: result = b;
            default:  result = '0;
        endcase
    end

    always_comb begin
        wb.valid = issue && (issue_pkt.unit_sel == UNIT_ALU);
        wb.rd = issue_pkt.rd;
        wb.data = result;
    end

endmodule

// File: verilog/branch_unit.sv
/* Branch compare and target. No prediction; a taken result redirects
   the pc when the instruction retires. */

`timescale 1ns/1ps

module branch_unit
    import rv_core_pkg::*;
    (
        input logic issue,
        input issue_packet_t issue_pkt,

        output branch_result_t result,
        output wb_packet_t wb
    );

    logic selected;
    logic cond;

    assign selected = issue && (issue_pkt.unit_sel == UNIT_BRANCH);

    always_comb begin
        case (issue_pkt.branch_op)
            BR_EQ:   cond = (issue_pkt.rs1 == issue_pkt.rs2);
            BR_NE:   cond = (issue_pkt.rs1 != issue_pkt.rs2);
            BR_LT:   cond = ($signed(issue_pkt.rs1) < $signed(issue_pkt.rs2));
            BR_GE:   cond = ($signed(issue_pkt.rs1) >= $signed(issue_pkt.rs2));
            BR_LTU:  cond = (issue_pkt.rs1 < issue_pkt.rs2);
            BR_GEU:  cond = (issue_pkt.rs1 >= issue_pkt.rs2);
            default: cond = 1'b1;
        endcase
    end

    always_comb begin
        result.taken = selected && cond;
        result.target = issue_pkt.pc + issue_pkt.imm;
        // Link value for JAL
        wb.valid = selected && (issue_pkt.branch_op == BR_JAL);
        wb.rd = issue_pkt.rd;
        wb.data = issue_pkt.pc + 32'd4;
    end

endmodule

// File: verilog/decode_issue.sv
/* Decoder and sequencer. Unsupported encodings issue with no unit selected
   and retire as no-ops. The first fetch waits one cycle after reset. */

`timescale 1ns/1ps

module decode_issue
    import rv_core_pkg::*;
    (
        input logic clk,
        input logic reset,

        input instr_t instr_rdata,
        input addr_t pc,
        input word_t rs1_data,
        input word_t rs2_data,

        output logic fetch_start,
        output reg_addr_t rs1_addr,
        output reg_addr_t rs2_addr,
        output logic issue,
        output issue_packet_t issue_pkt,
        output logic retire
    );

    core_state_e state;
    core_state_e next_state;
    logic started;
    issue_packet_t dec;

    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic f7_ok;
    word_t i_imm, s_imm, b_imm, u_imm, j_imm;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: alu_decode = alt ? ALU_SUB : ALU_ADD;
            3'b001: alu_decode = ALU_SLL;
            3'b010: alu_decode = ALU_SLT;
            3'b011: alu_decode = ALU_SLTU;
            3'b100: alu_decode = ALU_XOR;
            3'b101: alu_decode = alt ? ALU_SRA : ALU_SRL;
            3'b110: alu_decode = ALU_OR;
            default: alu_decode = ALU_AND;
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // Field extraction
    assign opcode = instr_rdata[6:0];
    assign funct3 = instr_rdata[14:12];
    assign funct7 = instr_rdata[31:25];
    assign rs1_addr = instr_rdata[19:15];
    assign rs2_addr = instr_rdata[24:20];

    // Alternate funct7 only for SUB and SRA
    assign f7_ok = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    assign i_imm = {{20{instr_rdata[31]}}, instr_rdata[31:20]};
    assign s_imm = {{20{instr_rdata[31]}}, instr_rdata[31:25], instr_rdata[11:7]};
    assign b_imm = {{19{instr_rdata[31]}}, instr_rdata[31], instr_rdata[7],
                    instr_rdata[30:25], instr_rdata[11:8], 1'b0};
    assign u_imm = {instr_rdata[31:12], 12'b0};
    assign j_imm = {{11{instr_rdata[31]}}, instr_rdata[31], instr_rdata[19:12],
                    instr_rdata[20], instr_rdata[30:21], 1'b0};

    ////////////////////////////////////////////////////
    // Decode
    always_comb begin
        dec = '0;
        dec.unit_sel = UNIT_NONE;
        dec.rs1 = rs1_data;
        dec.rs2 = rs2_data;
        dec.pc = pc;
        dec.rd = instr_rdata[11:7];
        case (opcode)
            OPC_OP: begin
                if (f7_ok) begin
                    dec.unit_sel = UNIT_ALU;
                end
                dec.alu_op = alu_decode(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                // Only shifts care about funct7
                if (funct3[1:0] != 2'b01 || f7_ok) begin
                    dec.unit_sel = UNIT_ALU;
                end
                dec.alu_op = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
                dec.use_imm = 1'b1;
                dec.imm = i_imm;
            end
            OPC_LUI: begin
                dec.unit_sel = UNIT_ALU;
                dec.alu_op = ALU_PASS;
                dec.use_imm = 1'b1;
                dec.imm = u_imm;
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    dec.unit_sel = UNIT_BRANCH;
                end
                case (funct3)
                    3'b000: dec.branch_op = BR_EQ;
                    3'b001: dec.branch_op = BR_NE;
                    3'b100: dec.branch_op = BR_LT;
                    3'b101: dec.branch_op = BR_GE;
                    3'b110: dec.branch_op = BR_LTU;
                    default: dec.branch_op = BR_GEU;
                endcase
                dec.imm = b_imm;
            end
            OPC_JAL: begin
                dec.unit_sel = UNIT_BRANCH;
                dec.branch_op = BR_JAL;
                dec.imm = j_imm;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec.unit_sel = UNIT_LOAD;
                end
                dec.imm = i_imm;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec.unit_sel = UNIT_STORE;
                end
                dec.imm = s_imm;
            end
            default: dec.unit_sel = UNIT_NONE;
        endcase
    end

    ////////////////////////////////////////////////////
    // Sequencer
    always_comb begin
        case (state)
            FETCH:    next_state = started ? DECODE : FETCH;
            DECODE:   next_state = EXECUTE;
            EXECUTE:  next_state = (issue_pkt.unit_sel == UNIT_LOAD) ? MEM_WAIT : FETCH;
            default:  next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            started <= 1'b0;
        end else begin
            state <= next_state;
            started <= 1'b1;
        end
    end

    // Operands captured at the end of decode
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            issue_pkt <= dec;
        end
    end

    assign fetch_start = (state == FETCH) && started;
    assign issue = (state == EXECUTE);
    assign retire = (state == MEM_WAIT) ||
                    (state == EXECUTE && issue_pkt.unit_sel != UNIT_LOAD);

endmodule

// File: verilog/fetch_unit.sv
/* Program counter and instruction request.
   The pc only moves on retire, so it is stable through decode and execute. */

`timescale 1ns/1ps

module fetch_unit
    import rv_core_pkg::*;
    #(
        parameter addr_t RESET_VECTOR = '0
    )
    (
        input logic clk,
        input logic reset,

        input logic fetch_start,
        input logic retire,
        input branch_result_t branch,

        output logic imem_req,
        output mem_req_t imem,
        output addr_t pc
    );

    // Strobe follows the sequencer directly
    assign imem_req = fetch_start;

    // Read-only port
    always_comb begin
        imem.addr = pc;
        imem.wdata = '0;
        imem.we = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (retire) begin
            if (branch.taken) begin
                pc <= branch.target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

// File: verilog/load_store_unit.sv
/* Word-only load/store unit. Addresses are assumed word aligned.
   Load data returns one cycle after the request and is written back then. */

`timescale 1ns/1ps

module load_store_unit
    import rv_core_pkg::*;
    (
        input logic clk,
        input logic reset,

        input logic issue,
        input issue_packet_t issue_pkt,
        input word_t dmem_rdata,

        output logic dmem_req,
        output mem_req_t dmem,
        output wb_packet_t wb
    );

    logic is_load;
    logic is_store;
    logic load_pending;
    reg_addr_t pending_rd;

    assign is_load = (issue_pkt.unit_sel == UNIT_LOAD);
    assign is_store = (issue_pkt.unit_sel == UNIT_STORE);

    assign dmem_req = issue && (is_load || is_store);

    always_comb begin
        dmem.addr = issue_pkt.rs1 + issue_pkt.imm;
        dmem.wdata = issue_pkt.rs2;
        dmem.we = is_store;
    end

    ////////////////////////////////////////////////////
    // Load return tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else begin
            load_pending <= issue && is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (issue && is_load) begin
            pending_rd <= issue_pkt.rd;
        end
    end

    always_comb begin
        wb.valid = load_pending;
        wb.rd = pending_rd;
        wb.data = dmem_rdata;
    end

endmodule

// File: verilog/register_file.sv
/* Thirty-two integer registers with combinational reads.
   Writers must not collide; x0 always reads zero. */

`timescale 1ns/1ps

module register_file
    import rv_core_pkg::*;
    (
        input logic clk,

        input reg_addr_t rs1_addr,
        input reg_addr_t rs2_addr,
        output word_t rs1_data,
        output word_t rs2_data,

        input wb_packet_t alu_wb,
        input wb_packet_t br_wb,
        input wb_packet_t ls_wb
    );

    word_t regs [32];
    wb_packet_t wr;

    // At most one unit writes in a cycle
    always_comb begin
        if (alu_wb.valid) begin
            wr = alu_wb;
        end else if (br_wb.valid) begin
            wr = br_wb;
        end else begin
            wr = ls_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/rv_core_pkg.sv
/* Shared types for the multi-cycle RV32I core.
   Only word-sized loads and stores exist; JALR and AUIPC are not decoded. */

package rv_core_pkg;

    ////////////////////////////////////////////////////
    // Plain vector types
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;

    ////////////////////////////////////////////////////
    // Enumerations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL
    } branch_op_e;

    typedef enum logic [2:0] {
        UNIT_NONE, UNIT_ALU, UNIT_BRANCH, UNIT_LOAD, UNIT_STORE
    } unit_sel_e;

    // Sequencer states, one instruction in flight
    typedef enum logic [1:0] {
        FETCH, DECODE, EXECUTE, MEM_WAIT
    } core_state_e;

    ////////////////////////////////////////////////////
    // Packets
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        unit_sel_e  unit_sel;
        alu_op_e    alu_op;
        branch_op_e branch_op;
        logic       use_imm;
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        word_t      pc;
        reg_addr_t  rd;
    } issue_packet_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_packet_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } branch_result_t;

    ////////////////////////////////////////////////////
    // Major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

endpackage

// File: verilog/rv_mini_core.sv
/* Multi-cycle RV32I core top. Memories are external, answer one cycle
   after the strobe and never stall. */

`timescale 1ns/1ps

module rv_mini_core
    import rv_core_pkg::*;
    #(
        parameter addr_t RESET_VECTOR = '0
    )
    (
        input logic clk,
        input logic reset,

        output logic imem_req,
        output mem_req_t imem,
        input instr_t instr_rdata,

        output logic dmem_req,
        output mem_req_t dmem,
        input word_t dmem_rdata
    );

    ////////////////////////////////////////////////////
    // Connecting signals
    logic fetch_start;
    logic retire;
    logic issue;
    addr_t pc;
    issue_packet_t issue_pkt;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    branch_result_t br_result;
    wb_packet_t alu_wb;
    wb_packet_t br_wb;
    wb_packet_t ls_wb;

    ////////////////////////////////////////////////////
    // Front end
    fetch_unit #(.RESET_VECTOR(RESET_VECTOR))
    fetch_block (
        .clk (clk),
        .reset (reset),
        .fetch_start (fetch_start),
        .retire (retire),
        .branch (br_result),
        .imem_req (imem_req),
        .imem (imem),
        .pc (pc)
    );

    decode_issue decode_issue_block (
        .clk (clk),
        .reset (reset),
        .instr_rdata (instr_rdata),
        .pc (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fetch_start (fetch_start),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .issue (issue),
        .issue_pkt (issue_pkt),
        .retire (retire)
    );

    register_file register_file_block (
        .clk (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_wb (alu_wb),
        .br_wb (br_wb),
        .ls_wb (ls_wb)
    );

    ////////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .issue (issue),
        .issue_pkt (issue_pkt),
        .wb (alu_wb)
    );

    branch_unit branch_unit_block (
        .issue (issue),
        .issue_pkt (issue_pkt),
        .result (br_result),
        .wb (br_wb)
    );

    load_store_unit load_store_unit_block (
        .clk (clk),
        .reset (reset),
        .issue (issue),
        .issue_pkt (issue_pkt),
        .dmem_rdata (dmem_rdata),
        .dmem_req (dmem_req),
        .dmem (dmem),
        .wb (ls_wb)
    );

endmodule
